// ==== project.f ====
+incdir+.
vdp_cpu_pkg.sv
vdp_video_pkg.sv
vdp_cpu_port.sv
vdp_raster_timing.sv
vdp_color_out.sv
vdp_top.sv
vdp_checker.sv
vdp_tb.sv

// ==== vdp_checker.sv ====
// Bound into vdp_top; samples on video_clk, and all checks except the reset check sleep during reset
`default_nettype none
`timescale 1ns/1ps

module vdp_checker (
    input wire       video_clk,
    input wire       reset,
    input wire       irq,
    input wire [3:0] video_r,
    input wire [3:0] video_g,
    input wire [3:0] video_b,
    input wire       video_de,
    input wire       video_hsync,
    input wire       video_vsync
);
    int unsigned fail_count = 0;

    // Blanked pixels carry no colour
    no_color_when_blank: assert property (@(posedge video_clk) disable iff (reset)
        !video_de |-> (video_r == 4'd0 && video_g == 4'd0 && video_b == 4'd0))
    else begin
        fail_count++;
        $error("colour nonzero while video_de is low");
    end

    // Pending flags start cleared
    irq_low_after_reset: assert property (@(posedge video_clk) reset |=> !irq)
    else begin
        fail_count++;
        $error("irq high in the cycle after reset");
    end

    strobes_known: assert property (@(posedge video_clk) disable iff (reset)
        !$isunknown({video_de, video_hsync, video_vsync, irq}))
    else begin
        fail_count++;
        $error("output strobe unknown after reset");
    end

endmodule

bind vdp_top vdp_checker checker_i (.*);

`default_nettype wire

// ==== vdp_color_out.sv ====
// Backdrop only, no tile data; colour and strobes trail the raster counters by two cycles
`default_nettype none
`timescale 1ns/1ps

module vdp_color_out (
    input  wire                              video_clk,
    input  wire                              reset,
    input  wire vdp_video_pkg::raster_t      raster,
    input  wire vdp_video_pkg::video_regs_t  vregs,
    input  wire vdp_cpu_pkg::pal_wr_t        pal_wr,
    output logic [3:0]                       video_r,
    output logic [3:0]                       video_g,
    output logic [3:0]                       video_b,
    output logic                             video_de,
    output logic                             video_hsync,
    output logic                             video_vsync
);
    import vdp_cpu_pkg::*;
    import vdp_video_pkg::*;

    pal_rgb_t palette [32];
    pal_rgb_t color_q;
    raster_t  raster_q;

    always_ff @(posedge video_clk) begin
        if (pal_wr.wren) begin
            palette[pal_wr.addr] <= pal_wr.data;
        end
    end

    ////////////////////////////////////////
    // Stage 1, lookup of entry 16 + backdrop
    ////////////////////////////////////////
    always_ff @(posedge video_clk) begin
        color_q <= palette[{1'b1, vregs.backdrop}];
    end

    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            raster_q <= '{hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
        end else begin
            raster_q <= raster;
        end
    end

    ////////////////////////////////////////
    // Stage 2, output registers
    ////////////////////////////////////////
    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            video_r     <= 4'd0;
            video_g     <= 4'd0;
            video_b     <= 4'd0;
            video_de    <= 1'b0;
            video_hsync <= 1'b0;
            video_vsync <= 1'b0;
        end else begin
            video_hsync <= raster_q.hsync;
            video_vsync <= raster_q.vsync;
            video_de    <= !raster_q.blank;
            if (raster_q.blank) begin
                video_r <= 4'd0;
                video_g <= 4'd0;
                video_b <= 4'd0;
            end else begin
                // 2-bit channels repeated to 4 bits
                video_r <= {color_q.red, color_q.red};
                video_g <= {color_q.green, color_q.green};
                video_b <= {color_q.blue, color_q.blue};
            end
        end
    end

endmodule

`default_nettype wire

// ==== vdp_cpu_pkg.sv ====
// Host-side types; register index is 4 bits wide and the palette holds 2 bits per channel
`default_nettype none

package vdp_cpu_pkg;

    // One host access, strobes last a single cycle
    typedef struct packed {
        logic       portsel;    // 0 data, 1 control
        logic [7:0] wrdata;
        logic       wren;
        logic       rddone;
        logic       wrdone;
    } cpu_bus_t;

    // Second control byte, address form
    typedef struct packed {
        logic [1:0] code;
        logic [5:0] addr_hi;
    } ctrl_addr_t;

    // Second control byte, register-write form
    typedef struct packed {
        logic [1:0] code;
        logic [1:0] spare;
        logic [3:0] reg_idx;
    } ctrl_reg_t;

    typedef union packed {
        ctrl_addr_t addr_view;
        ctrl_reg_t  reg_view;
    } ctrl_hi_u;

    typedef struct packed {
        logic [1:0] blue;
        logic [1:0] green;
        logic [1:0] red;
    } pal_rgb_t;

    typedef struct packed {
        logic       wren;
        logic [4:0] addr;
        pal_rgb_t   data;
    } pal_wr_t;

endpackage

`default_nettype wire

// ==== vdp_cpu_port.sv ====
// Single clock, no wait states; only status bit 7 is live and registers other than 0/1/7/10 are ignored
`default_nettype none
`timescale 1ns/1ps
`include "vdp_defines.svh"

module vdp_cpu_port (
    input  wire                              video_clk,
    input  wire                              reset,
    input  wire vdp_cpu_pkg::cpu_bus_t       cpu,
    output logic [7:0]                       rddata,
    output logic                             irq,
    input  wire                              frame_pulse,
    input  wire                              line_pulse,
    output vdp_video_pkg::video_regs_t       vregs,
    output vdp_cpu_pkg::pal_wr_t             pal_wr
);
    import vdp_cpu_pkg::*;
    import vdp_video_pkg::*;

    localparam int VRAM_DEPTH = 1 << `VRAM_ADDR_BITS;

    ctrl_hi_u    ctrl_hi;
    logic        ctrl_write;
    logic        data_write;
    logic        ctrl_rddone;
    logic        data_done;
    logic        reg_write;

    logic        toggle;
    logic [1:0]  code;
    logic [13:0] addr;
    logic [7:0]  vram [VRAM_DEPTH];

    logic        line_irq_en;
    logic        frame_irq_en;
    logic [3:0]  backdrop;
    logic [7:0]  line_reload;
    logic        frame_pend;
    logic        line_pend;

    ////////////////////////////////////////
    // Port decode
    ////////////////////////////////////////
    assign ctrl_hi     = cpu.wrdata;
    assign ctrl_write  = cpu.wren && cpu.portsel;
    assign data_write  = cpu.wren && !cpu.portsel;
    assign ctrl_rddone = cpu.rddone && cpu.portsel;
    assign data_done   = (cpu.rddone || cpu.wrdone) && !cpu.portsel;
    assign reg_write   = ctrl_write && toggle && (ctrl_hi.reg_view.code == `CODE_REG_WRITE);

    // Byte toggle, code and auto-incrementing address
    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            toggle <= 1'b0;
            code   <= 2'd0;
            addr   <= 14'd0;
        end else begin
            if (ctrl_write) begin
                if (!toggle) begin
                    addr[7:0] <= cpu.wrdata;
                end else begin
                    code       <= ctrl_hi.addr_view.code;
                    addr[13:8] <= ctrl_hi.addr_view.addr_hi;
                end
                toggle <= !toggle;
            end
            if (ctrl_rddone) begin
                toggle <= 1'b0;
            end
            // Any data access steps to the next byte
            if (data_done) begin
                toggle <= 1'b0;
                addr   <= addr + 14'd1;
            end
        end
    end

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////
    // Value comes from the low address byte of the first write
    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            line_irq_en  <= 1'b0;
            frame_irq_en <= 1'b0;
            backdrop     <= 4'd0;
            line_reload  <= 8'd0;
        end else if (reg_write) begin
            case (ctrl_hi.reg_view.reg_idx)
                `REG_MODE0:    line_irq_en  <= addr[4];
                `REG_MODE1:    frame_irq_en <= addr[5];
                `REG_BACKDROP: backdrop     <= addr[3:0];
                `REG_LINE_IRQ: line_reload  <= addr[7:0];
                default:       ;
            endcase
        end
    end

    // VRAM, written at the current address before the increment
    always_ff @(posedge video_clk) begin
        if (data_write && code != `CODE_PALETTE) begin
            vram[addr[`VRAM_ADDR_BITS-1:0]] <= cpu.wrdata;
        end
    end

    ////////////////////////////////////////
    // Pending flags and interrupt
    ////////////////////////////////////////
    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            frame_pend <= 1'b0;
            line_pend  <= 1'b0;
        end else begin
            if (ctrl_rddone) begin
                frame_pend <= 1'b0;
                line_pend  <= 1'b0;
            end
            // A pulse in the clearing cycle still sets its flag
            if (frame_pulse) begin
                frame_pend <= 1'b1;
            end
            if (line_pulse) begin
                line_pend <= 1'b1;
            end
        end
    end

    assign irq = (frame_pend && frame_irq_en) || (line_pend && line_irq_en);

    assign rddata = cpu.portsel ? {frame_pend, 7'b0} : vram[addr[`VRAM_ADDR_BITS-1:0]];

    assign vregs.backdrop    = backdrop;
    assign vregs.line_reload = line_reload;

    // Palette writes leave for the output side
    always_comb begin
        pal_wr.wren = data_write && (code == `CODE_PALETTE);
        pal_wr.addr = addr[4:0];
        pal_wr.data = cpu.wrdata[5:0];
    end

endmodule

`default_nettype wire

// ==== vdp_defines.svh ====
// Raster numbers assume a 256x192 NTSC-style frame; VRAM decodes only the low VRAM_ADDR_BITS
`ifndef VDP_DEFINES_SVH
`define VDP_DEFINES_SVH

////////////////////////////////////////
// Horizontal timing in dots
////////////////////////////////////////
`define H_TOTAL         342
`define H_ACTIVE        256
`define HSYNC_START     280
`define HSYNC_END       306

////////////////////////////////////////
// Vertical timing in lines
////////////////////////////////////////
`define V_TOTAL         262
`define V_ACTIVE        192
`define VSYNC_START     216
`define VSYNC_END       219

// VRAM depth as address bits
`define VRAM_ADDR_BITS  10

////////////////////////////////////////
// Register indices and access codes
////////////////////////////////////////
`define REG_MODE0       0
`define REG_MODE1       1
`define REG_BACKDROP    7
`define REG_LINE_IRQ    10

`define CODE_VRAM_READ  0
`define CODE_REG_WRITE  2
`define CODE_PALETTE    3

`endif

// ==== vdp_raster_timing.sv ====
// Fixed NTSC-style timing from the defines; strobes are combinational, pulses registered
`default_nettype none
`timescale 1ns/1ps
`include "vdp_defines.svh"

module vdp_raster_timing (
    input  wire                              video_clk,
    input  wire                              reset,
    input  wire vdp_video_pkg::video_regs_t  vregs,
    output vdp_video_pkg::raster_t           raster,
    output logic                             frame_pulse,
    output logic                             line_pulse,
    output logic                             newframe,
    output logic [7:0]                       vcnt
);
    logic [8:0] h_count;
    logic [8:0] v_count;
    logic [8:0] v_next;
    logic       h_wrap;
    logic [7:0] line_cnt;

    ////////////////////////////////////////
    // Dot and line counters
    ////////////////////////////////////////
    assign h_wrap = (h_count == 9'(`H_TOTAL - 1));
    assign v_next = (v_count == 9'(`V_TOTAL - 1)) ? 9'd0 : v_count + 9'd1;

    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            h_count <= 9'd0;
            v_count <= 9'd0;
        end else begin
            h_count <= h_wrap ? 9'd0 : h_count + 9'd1;
            if (h_wrap) begin
                v_count <= v_next;
            end
        end
    end

    // Sync and blanking decode
    always_comb begin
        raster.hsync = (h_count >= `HSYNC_START) && (h_count < `HSYNC_END);
        raster.vsync = (v_count >= `VSYNC_START) && (v_count < `VSYNC_END);
        raster.blank = (h_count >= `H_ACTIVE) || (v_count >= `V_ACTIVE);
    end

    assign vcnt = v_count[7:0];

    ////////////////////////////////////////
    // Frame and line pulses
    ////////////////////////////////////////
    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            frame_pulse <= 1'b0;
            newframe    <= 1'b0;
            line_pulse  <= 1'b0;
            line_cnt    <= 8'd0;
        end else begin
            frame_pulse <= h_wrap && (v_next == `V_ACTIVE);
            newframe    <= h_wrap && (v_next == 9'd0);
            line_pulse  <= 1'b0;
            if (h_wrap) begin
                // Counts down through the active lines, reloads below them
                if (v_next <= `V_ACTIVE) begin
                    if (line_cnt == 8'd0) begin
                        line_pulse <= 1'b1;
                        line_cnt   <= vregs.line_reload;
                    end else begin
                        line_cnt <= line_cnt - 8'd1;
                    end
                end else begin
                    line_cnt <= vregs.line_reload;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== vdp_tb.sv ====
// Self-checking testbench; VRAM and palette reads only cover locations the test wrote first
`default_nettype none
`timescale 1ns/1ps
`include "vdp_defines.svh"

module vdp_tb;
    import vdp_cpu_pkg::*;

    localparam int TIMEOUT      = `H_TOTAL * `V_TOTAL + 1000;
    localparam int SIG_IRQ      = 0;
    localparam int SIG_DE       = 1;
    localparam int SIG_NEWFRAME = 2;
    localparam int SIG_VSYNC    = 3;

    logic       video_clk;
    logic       reset;
    cpu_bus_t   cpu;
    wire [7:0]  rddata;
    wire        irq;
    wire [7:0]  vcnt;
    wire [3:0]  video_r;
    wire [3:0]  video_g;
    wire [3:0]  video_b;
    wire        video_de;
    wire        video_hsync;
    wire        video_vsync;
    wire        video_newframe;

    logic [31:0] seed;
    int          errors;
    int          checks;
    int          tests_failed;

    // Reference model state
    logic        m_toggle;
    logic [1:0]  m_code;
    logic [13:0] m_addr;
    logic [7:0]  m_vram [1 << `VRAM_ADDR_BITS];
    logic [5:0]  m_pal [32];
    logic        m_line_en;
    logic        m_frame_en;
    logic [3:0]  m_backdrop;
    logic [7:0]  m_line_reload;
    logic        m_frame_pend;

    vdp_top dut_i (
        .video_clk      (video_clk),
        .reset          (reset),
        .cpu            (cpu),
        .rddata         (rddata),
        .irq            (irq),
        .vcnt           (vcnt),
        .video_r        (video_r),
        .video_g        (video_g),
        .video_b        (video_b),
        .video_de       (video_de),
        .video_hsync    (video_hsync),
        .video_vsync    (video_vsync),
        .video_newframe (video_newframe)
    );

    always #2 video_clk = ~video_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SIG_IRQ:   return irq;
            SIG_DE:    return video_de;
            SIG_VSYNC: return video_vsync;
            default:   return video_newframe;
        endcase
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge video_clk);
        #1;
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic wait_level(input int sel, input logic level, input string what);
        int  i;
        bit  found;
        found = 1'b0;
        for (i = 0; i < TIMEOUT && !found; i++) begin
            if (probe(sel) === level) begin
                found = 1'b1;
            end else begin
                step();
            end
        end
        assert (found) else begin
            errors++;
            $display("timeout while waiting for %s", what);
        end
    endtask

    task automatic bus_idle();
        cpu = '0;
    endtask

    ////////////////////////////////////////
    // Bus accesses with model update
    ////////////////////////////////////////
    task automatic ctrl_write(input logic [7:0] b);
        cpu = '{portsel: 1'b1, wrdata: b, wren: 1'b1, rddone: 1'b0, wrdone: 1'b0};
        step();
        bus_idle();
        if (!m_toggle) begin
            m_addr[7:0] = b;
        end else begin
            m_code       = b[7:6];
            m_addr[13:8] = b[5:0];
            // Register value is the low address byte
            if (b[7:6] == 2'(`CODE_REG_WRITE)) begin
                case (b[3:0])
                    4'(`REG_MODE0):    m_line_en     = m_addr[4];
                    4'(`REG_MODE1):    m_frame_en    = m_addr[5];
                    4'(`REG_BACKDROP): m_backdrop    = m_addr[3:0];
                    4'(`REG_LINE_IRQ): m_line_reload = m_addr[7:0];
                    default:           ;
                endcase
            end
        end
        m_toggle = !m_toggle;
    endtask

    task automatic set_addr(input logic [13:0] a, input logic [1:0] code);
        ctrl_write(a[7:0]);
        ctrl_write({code, a[13:8]});
    endtask

    task automatic reg_write(input logic [3:0] idx, input logic [7:0] val);
        ctrl_write(val);
        ctrl_write({2'(`CODE_REG_WRITE), 2'b00, idx});
    endtask

    task automatic data_write(input logic [7:0] b);
        cpu = '{portsel: 1'b0, wrdata: b, wren: 1'b1, rddone: 1'b0, wrdone: 1'b1};
        step();
        bus_idle();
        if (m_code == 2'(`CODE_PALETTE)) begin
            m_pal[m_addr[4:0]] = b[5:0];
        end else begin
            m_vram[m_addr[`VRAM_ADDR_BITS-1:0]] = b;
        end
        m_addr   = m_addr + 14'd1;
        m_toggle = 1'b0;
    endtask

    task automatic data_read();
        logic [7:0] got;
        cpu = '{portsel: 1'b0, wrdata: 8'd0, wren: 1'b0, rddone: 1'b1, wrdone: 1'b0};
        #1;
        got = rddata;
        step();
        bus_idle();
        check_byte("rddata", got, m_vram[m_addr[`VRAM_ADDR_BITS-1:0]]);
        m_addr   = m_addr + 14'd1;
        m_toggle = 1'b0;
    endtask

    task automatic status_read(output logic [7:0] got);
        cpu = '{portsel: 1'b1, wrdata: 8'd0, wren: 1'b0, rddone: 1'b1, wrdone: 1'b0};
        #1;
        got = rddata;
        step();
        bus_idle();
        m_toggle     = 1'b0;
        m_frame_pend = 1'b0;
    endtask

    // Services every irq until the next frame start
    task automatic count_frame(output int cnt);
        int          i;
        bit          done;
        logic [7:0]  st;
        cnt  = 0;
        done = 1'b0;
        for (i = 0; i < TIMEOUT && !done; i++) begin
            step();
            if (video_newframe) begin
                done = 1'b1;
            end else if (irq) begin
                cnt++;
                status_read(st);
            end
        end
        assert (done) else begin
            errors++;
            $display("timeout while counting line interrupts");
        end
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
        end
    endtask

    initial begin
        logic [7:0]  st;
        logic [31:0] r;
        logic [13:0] a;
        logic [5:0]  e;
        logic        exp_de;
        logic        exp_hs;
        int          err0;
        int          i;
        int          n;
        int          cnt;
        int          exp_cnt;
        int          nsamp;
        int          h;
        int          v;

        video_clk     = 1'b0;
        reset         = 1'b1;
        cpu           = '0;
        seed          = 32'h766f;
        errors        = 0;
        checks        = 0;
        tests_failed  = 0;
        m_toggle      = 1'b0;
        m_code        = 2'd0;
        m_addr        = 14'd0;
        m_line_en     = 1'b0;
        m_frame_en    = 1'b0;
        m_backdrop    = 4'd0;
        m_line_reload = 8'd0;
        m_frame_pend  = 1'b0;
        repeat (10) @(posedge video_clk);
        #1;
        reset = 1'b0;

        // 1: state out of reset
        err0 = errors;
        check_byte("irq", {7'd0, irq}, {7'd0, m_frame_pend & m_frame_en});
        check_byte("video_de", {7'd0, video_de}, 8'd0);
        status_read(st);
        check_byte("status", st, 8'h00);
        end_test(1, "reset state", err0);

        ////////////////////////////////////////
        // 2: VRAM round trip
        ////////////////////////////////////////
        err0 = errors;
        r = next_random();
        ctrl_write(r[7:0]);
        // Lone first byte, then a control read must rewind the toggle
        status_read(st);
        r = next_random();
        a = r[13:0];
        set_addr(a, 2'd1);
        for (i = 0; i < 16; i++) begin
            r = next_random();
            data_write(r[7:0]);
        end
        set_addr(a, 2'(`CODE_VRAM_READ));
        for (i = 0; i < 16; i++) begin
            data_read();
        end
        end_test(2, "vram round trip", err0);

        // 3: palette and backdrop colour
        err0 = errors;
        set_addr(14'd0, 2'(`CODE_PALETTE));
        for (i = 0; i < 32; i++) begin
            r = next_random();
            data_write(r[7:0]);
        end
        r = next_random();
        reg_write(4'(`REG_BACKDROP), r[7:0]);
        wait_level(SIG_DE, 1'b0, "video_de low");
        wait_level(SIG_DE, 1'b1, "video_de high");
        e     = m_pal[{1'b1, m_backdrop}];
        nsamp = 0;
        // Output dot 0 of the line the counters are still on
        h = 0;
        v = int'(vcnt);
        for (i = 0; i < 2 * `H_TOTAL; i++) begin
            exp_de = (h < `H_ACTIVE) && (v < `V_ACTIVE);
            exp_hs = (h >= `HSYNC_START) && (h < `HSYNC_END);
            check_byte("video_de", {7'd0, video_de}, {7'd0, exp_de});
            check_byte("video_hsync", {7'd0, video_hsync}, {7'd0, exp_hs});
            if (video_de) begin
                check_byte("video_r", {4'd0, video_r}, {4'd0, e[1:0], e[1:0]});
                check_byte("video_g", {4'd0, video_g}, {4'd0, e[3:2], e[3:2]});
                check_byte("video_b", {4'd0, video_b}, {4'd0, e[5:4], e[5:4]});
                nsamp++;
            end
            step();
            h++;
            if (h == `H_TOTAL) begin
                h = 0;
                v = (v + 1) % `V_TOTAL;
            end
        end
        assert (nsamp > 0) else begin
            errors++;
            $display("no active pixels were seen in the sampled lines");
        end
        end_test(3, "palette and backdrop", err0);

        ////////////////////////////////////////
        // 4: frame interrupt
        ////////////////////////////////////////
        err0 = errors;
        reg_write(4'(`REG_MODE1), 8'h20);
        status_read(st);
        wait_level(SIG_IRQ, 1'b1, "frame irq");
        m_frame_pend = 1'b1;
        check_byte("vcnt", vcnt, 8'(`V_ACTIVE));
        status_read(st);
        check_byte("status", st, 8'h80);
        check_byte("irq", {7'd0, irq}, {7'd0, m_frame_pend & m_frame_en});
        status_read(st);
        check_byte("status", st, {m_frame_pend, 7'd0});
        // Vertical sync edges trail their lines by two dots
        wait_level(SIG_VSYNC, 1'b1, "video_vsync high");
        check_byte("vcnt", vcnt, 8'(`VSYNC_START));
        wait_level(SIG_VSYNC, 1'b0, "video_vsync low");
        check_byte("vcnt", vcnt, 8'(`VSYNC_END));
        reg_write(4'(`REG_MODE1), 8'h00);
        end_test(4, "frame interrupt", err0);

        // 5: line interrupt, one frame to settle the reload, then one counted
        err0 = errors;
        r = next_random();
        n = int'(r[4:0]);
        reg_write(4'(`REG_LINE_IRQ), 8'(n));
        reg_write(4'(`REG_MODE0), 8'h10);
        wait_level(SIG_NEWFRAME, 1'b1, "video_newframe");
        count_frame(cnt);
        count_frame(cnt);
        exp_cnt = m_line_en ? (`V_ACTIVE + 1) / (int'(m_line_reload) + 1) : 0;
        check_byte("line_irq_count", 8'(cnt), 8'(exp_cnt));
        reg_write(4'(`REG_MODE0), 8'h00);
        end_test(5, "line interrupt", err0);

        errors = errors + int'(dut_i.checker_i.fail_count);
        $display("tests 5, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vdp_top.sv ====
// Register side and raster output on one clock; no tile or sprite renderer behind the backdrop
`default_nettype none
`timescale 1ns/1ps

module vdp_top (
    input  wire                         video_clk,
    input  wire                         reset,
    input  wire vdp_cpu_pkg::cpu_bus_t  cpu,
    output wire [7:0]                   rddata,
    output wire                         irq,
    output wire [7:0]                   vcnt,
    output wire [3:0]                   video_r,
    output wire [3:0]                   video_g,
    output wire [3:0]                   video_b,
    output wire                         video_de,
    output wire                         video_hsync,
    output wire                         video_vsync,
    output wire                         video_newframe
);
    import vdp_cpu_pkg::*;
    import vdp_video_pkg::*;

    video_regs_t vregs;
    raster_t     raster;
    pal_wr_t     pal_wr;
    logic        frame_pulse;
    logic        line_pulse;

    vdp_cpu_port cpu_port_i (
        .video_clk   (video_clk),
        .reset       (reset),
        .cpu         (cpu),
        .rddata      (rddata),
        .irq         (irq),
        .frame_pulse (frame_pulse),
        .line_pulse  (line_pulse),
        .vregs       (vregs),
        .pal_wr      (pal_wr)
    );

    vdp_raster_timing timing_i (
        .video_clk   (video_clk),
        .reset       (reset),
        .vregs       (vregs),
        .raster      (raster),
        .frame_pulse (frame_pulse),
        .line_pulse  (line_pulse),
        .newframe    (video_newframe),
        .vcnt        (vcnt)
    );

    vdp_color_out color_i (
        .video_clk   (video_clk),
        .reset       (reset),
        .raster      (raster),
        .vregs       (vregs),
        .pal_wr      (pal_wr),
        .video_r     (video_r),
        .video_g     (video_g),
        .video_b     (video_b),
        .video_de    (video_de),
        .video_hsync (video_hsync),
        .video_vsync (video_vsync)
    );

endmodule

`default_nettype wire

// ==== vdp_video_pkg.sv ====
// Video-side types; only backdrop and line reload reach the raster path
`default_nettype none

package vdp_video_pkg;

    // Register values seen by the video side
    typedef struct packed {
        logic [3:0] backdrop;
        logic [7:0] line_reload;
    } video_regs_t;

    // Raster strobes straight from the counters
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic blank;
    } raster_t;

endpackage

`default_nettype wire
